// ==== hw/id_consts.svh ====
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

`define DATA_W      32
`define REG_AW      5
`define NUM_REGS    32
`define LINK_REG    31
`define MEM_WEN_W   4

// opcodes
`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_LW       6'b100011
`define OP_SW       6'b101011

// funct codes under OP_SPECIAL
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_JR       6'b001000
`define FN_JALR     6'b001001
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011

// rt codes under OP_REGIMM
`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001
`define RT_BLTZAL   5'b10000
`define RT_BGEZAL   5'b10001

// one-hot alu operation, add in the msb
`define ALU_OP_W    12
`define ALU_ADD     11
`define ALU_SUB     10
`define ALU_SLT     9
`define ALU_SLTU    8
`define ALU_AND     7
`define ALU_NOR     6
`define ALU_OR      5
`define ALU_XOR     4
`define ALU_SLL     3
`define ALU_SRL     2
`define ALU_SRA     1
`define ALU_LUI     0

`define SRC1_W      3
`define SRC1_RS     0
`define SRC1_PC     1
`define SRC1_SA     2

`define SRC2_W      4
`define SRC2_RT     0
`define SRC2_SIMM   1
`define SRC2_C8     2
`define SRC2_ZIMM   3

// one-hot branch select
`define BR_SEL_W    8
`define BR_EQ       0
`define BR_NE       1
`define BR_GEZ      2
`define BR_GTZ      3
`define BR_LEZ      4
`define BR_LTZ      5
`define BR_J        6
`define BR_JR       7

`endif

// ==== hw/id_pkg.sv ====
`include "id_consts.svh"

package id_pkg;

    typedef struct packed {
        logic [5:0]         opcode;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] shamt;
        logic [5:0]         funct;
    } r_fmt_t;

    typedef struct packed {
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [15:0]        imm16;
    } i_fields_t;

    // low 26 bits are either rs/rt/imm16 or the jump index
    typedef struct packed {
        logic [5:0] opcode;
        union packed {
            i_fields_t   f;
            logic [25:0] index;
        } body;
    } ij_fmt_t;

    typedef union packed {
        r_fmt_t  r;
        ij_fmt_t ij;
    } instr_u;

endpackage

// ==== hw/rf_read_if.sv ====
`timescale 1ns/1ps
`include "id_consts.svh"

interface rf_read_if;

    logic [`REG_AW-1:0] rs_addr;
    logic [`REG_AW-1:0] rt_addr;
    logic [`DATA_W-1:0] rs_data;
    logic [`DATA_W-1:0] rt_data;

    modport reader (
        output rs_addr,
        output rt_addr,
        input  rs_data,
        input  rt_data
    );

    modport source (
        input  rs_addr,
        input  rt_addr,
        output rs_data,
        output rt_data
    );

    modport monitor (
        input rs_data,
        input rt_data
    );

endinterface

// ==== hw/id_pipe_reg.sv ====
`timescale 1ns/1ps
`include "id_consts.svh"

module id_pipe_reg (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall_if,
    input  logic               stall_id,
    input  logic               in_valid,
    input  logic [`DATA_W-1:0] in_pc,
    input  id_pkg::instr_u     in_inst,
    output logic               valid,
    output logic [`DATA_W-1:0] pc,
    output id_pkg::instr_u     inst
);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            pc    <= '0;
            inst  <= '0;
        end else if (stall_if && !stall_id) begin
            // fetch stalled but id moves on, so send a bubble
            valid <= 1'b0;
            pc    <= '0;
            inst  <= '0;
        end else if (!stall_if) begin
            valid <= in_valid;
            pc    <= in_pc;
            inst  <= in_inst;
        end
    end

    // a stalled id stage must also hold fetch
    stall_order: assert property (@(posedge clk) disable iff (rst) stall_id |-> stall_if)
        else $error("stall_id without stall_if");

endmodule

// ==== hw/inst_decoder.sv ====
`timescale 1ns/1ps
`include "id_consts.svh"

module inst_decoder (
    input  logic                  valid,
    input  id_pkg::instr_u        inst,
    output logic [`ALU_OP_W-1:0]  alu_op,
    output logic [`SRC1_W-1:0]    alu_src1,
    output logic [`SRC2_W-1:0]    alu_src2,
    output logic                  mem_en,
    output logic [`MEM_WEN_W-1:0] mem_wen,
    output logic                  rf_we,
    output logic [`REG_AW-1:0]    rf_waddr,
    output logic [`BR_SEL_W-1:0]  br_sel,
    rf_read_if.reader             rf
);

    logic [5:0] opcode;
    logic       special;
    logic       special_ns;
    logic       regimm;
    logic is_addu, is_subu, is_add, is_sub, is_and, is_or, is_xor, is_nor;
    logic is_slt, is_sltu, is_sll, is_srl, is_sra, is_sllv, is_srlv, is_srav;
    logic is_jr, is_jalr, is_addiu, is_addi, is_andi, is_ori, is_xori, is_lui;
    logic is_slti, is_sltiu, is_lw, is_sw, is_beq, is_bne, is_bgez, is_bgtz;
    logic is_blez, is_bltz, is_bgezal, is_bltzal, is_j, is_jal;
    logic r_alu;
    logic r_shift_imm;
    logic i_simm;
    logic i_zimm;
    logic link;
    logic dst_rd;
    logic dst_rt;
    logic dst_link;

    // valid folds in here so every flag below is already gated
    assign opcode     = valid ? inst.r.opcode : 6'b111111;
    assign special    = valid && (inst.r.opcode == `OP_SPECIAL);
    // non-shift r-type needs shamt zero
    assign special_ns = special && (inst.r.shamt == '0);
    assign regimm     = valid && (inst.r.opcode == `OP_REGIMM);

    assign is_addu   = special_ns && (inst.r.funct == `FN_ADDU);
    assign is_subu   = special_ns && (inst.r.funct == `FN_SUBU);
    assign is_add    = special_ns && (inst.r.funct == `FN_ADD);
    assign is_sub    = special_ns && (inst.r.funct == `FN_SUB);
    assign is_and    = special_ns && (inst.r.funct == `FN_AND);
    assign is_or     = special_ns && (inst.r.funct == `FN_OR);
    assign is_xor    = special_ns && (inst.r.funct == `FN_XOR);
    assign is_nor    = special_ns && (inst.r.funct == `FN_NOR);
    assign is_slt    = special_ns && (inst.r.funct == `FN_SLT);
    assign is_sltu   = special_ns && (inst.r.funct == `FN_SLTU);
    assign is_sllv   = special_ns && (inst.r.funct == `FN_SLLV);
    assign is_srlv   = special_ns && (inst.r.funct == `FN_SRLV);
    assign is_srav   = special_ns && (inst.r.funct == `FN_SRAV);
    assign is_jr     = special_ns && (inst.r.funct == `FN_JR);
    assign is_jalr   = special_ns && (inst.r.funct == `FN_JALR);
    assign is_sll    = special && (inst.r.funct == `FN_SLL);
    assign is_srl    = special && (inst.r.funct == `FN_SRL);
    assign is_sra    = special && (inst.r.funct == `FN_SRA);
    assign is_addiu  = (opcode == `OP_ADDIU);
    assign is_addi   = (opcode == `OP_ADDI);
    assign is_andi   = (opcode == `OP_ANDI);
    assign is_ori    = (opcode == `OP_ORI);
    assign is_xori   = (opcode == `OP_XORI);
    assign is_lui    = (opcode == `OP_LUI);
    assign is_slti   = (opcode == `OP_SLTI);
    assign is_sltiu  = (opcode == `OP_SLTIU);
    assign is_lw     = (opcode == `OP_LW);
    assign is_sw     = (opcode == `OP_SW);
    assign is_beq    = (opcode == `OP_BEQ);
    assign is_bne    = (opcode == `OP_BNE);
    assign is_bgtz   = (opcode == `OP_BGTZ);
    assign is_blez   = (opcode == `OP_BLEZ);
    assign is_j      = (opcode == `OP_J);
    assign is_jal    = (opcode == `OP_JAL);
    assign is_bgez   = regimm && (inst.ij.body.f.rt == `RT_BGEZ);
    assign is_bltz   = regimm && (inst.ij.body.f.rt == `RT_BLTZ);
    assign is_bgezal = regimm && (inst.ij.body.f.rt == `RT_BGEZAL);
    assign is_bltzal = regimm && (inst.ij.body.f.rt == `RT_BLTZAL);

    assign r_alu = is_addu | is_subu | is_add | is_sub | is_and | is_or | is_xor | is_nor
                 | is_slt | is_sltu | is_sllv | is_srlv | is_srav;
    assign r_shift_imm = is_sll | is_srl | is_sra;
    assign i_simm      = is_addi | is_addiu | is_slti | is_sltiu | is_lui;
    assign i_zimm      = is_andi | is_ori | is_xori;
    assign link        = is_jal | is_bgezal | is_bltzal | is_jalr;

    assign alu_op[`ALU_ADD]  = is_addu | is_add | is_addiu | is_addi | is_lw | is_sw | link;
    assign alu_op[`ALU_SUB]  = is_subu | is_sub;
    assign alu_op[`ALU_SLT]  = is_slt | is_slti;
    assign alu_op[`ALU_SLTU] = is_sltu | is_sltiu;
    assign alu_op[`ALU_AND]  = is_and | is_andi;
    assign alu_op[`ALU_NOR]  = is_nor;
    assign alu_op[`ALU_OR]   = is_or | is_ori;
    assign alu_op[`ALU_XOR]  = is_xor | is_xori;
    assign alu_op[`ALU_SLL]  = is_sll | is_sllv;
    assign alu_op[`ALU_SRL]  = is_srl | is_srlv;
    assign alu_op[`ALU_SRA]  = is_sra | is_srav;
    assign alu_op[`ALU_LUI]  = is_lui;

    assign alu_src1[`SRC1_RS] = r_alu | i_simm | i_zimm | is_lw | is_sw;
    assign alu_src1[`SRC1_PC] = link;
    assign alu_src1[`SRC1_SA] = r_shift_imm;

    assign alu_src2[`SRC2_RT]   = r_alu | r_shift_imm;
    assign alu_src2[`SRC2_SIMM] = i_simm | is_lw | is_sw;
    assign alu_src2[`SRC2_C8]   = link;
    assign alu_src2[`SRC2_ZIMM] = i_zimm;

    assign mem_en  = is_lw | is_sw;
    assign mem_wen = {`MEM_WEN_W{is_sw}};

    assign dst_rd   = r_alu | r_shift_imm | is_jalr;
    assign dst_rt   = i_simm | i_zimm | is_lw;
    assign dst_link = is_jal | is_bgezal | is_bltzal;
    assign rf_we    = dst_rd | dst_rt | dst_link;
    assign rf_waddr = dst_rd   ? inst.r.rd :
                      dst_rt   ? inst.r.rt :
                      dst_link ? `REG_AW'(`LINK_REG) : '0;

    assign br_sel[`BR_EQ]  = is_beq;
    assign br_sel[`BR_NE]  = is_bne;
    assign br_sel[`BR_GEZ] = is_bgez | is_bgezal;
    assign br_sel[`BR_GTZ] = is_bgtz;
    assign br_sel[`BR_LEZ] = is_blez;
    assign br_sel[`BR_LTZ] = is_bltz | is_bltzal;
    assign br_sel[`BR_J]   = is_j | is_jal;
    assign br_sel[`BR_JR]  = is_jr | is_jalr;

    assign rf.rs_addr = inst.r.rs;
    assign rf.rt_addr = inst.r.rt;

    // the ex stage muxes assume one source per operand
    src_onehot: assert final ($onehot0(alu_src1) && $onehot0(alu_src2))
        else $error("alu source select not one-hot");

endmodule

// ==== hw/operand_fetch.sv ====
`timescale 1ns/1ps
`include "id_consts.svh"

module operand_fetch (
    input  logic               clk,
    input  logic               valid,
    input  logic               ex_we,
    input  logic [`REG_AW-1:0] ex_waddr,
    input  logic [`DATA_W-1:0] ex_wdata,
    input  logic               ex_is_load,
    input  logic               mem_we,
    input  logic [`REG_AW-1:0] mem_waddr,
    input  logic [`DATA_W-1:0] mem_wdata,
    input  logic               wb_we,
    input  logic [`REG_AW-1:0] wb_waddr,
    input  logic [`DATA_W-1:0] wb_wdata,
    output logic               stall_req,
    rf_read_if.source          rf
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    // youngest producer wins, array last
    function automatic logic [`DATA_W-1:0] read_port(input logic [`REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (ex_we && ex_waddr == addr) begin
            return ex_wdata;
        end else if (mem_we && mem_waddr == addr) begin
            return mem_wdata;
        end else if (wb_we && wb_waddr == addr) begin
            return wb_wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_we) begin
            regs[wb_waddr] <= wb_wdata;
        end
    end

    always_comb begin
        rf.rs_data = read_port(rf.rs_addr);
        rf.rt_data = read_port(rf.rt_addr);
    end

    // load result not ready until mem, hold id one cycle
    assign stall_req = valid && ex_is_load && ex_we
                    && (ex_waddr == rf.rs_addr || ex_waddr == rf.rt_addr);

    load_use_only: assert property (@(posedge clk) stall_req |-> ex_is_load)
        else $error("stall requested without a load in ex");

endmodule

// ==== hw/branch_unit.sv ====
`timescale 1ns/1ps
`include "id_consts.svh"

module branch_unit (
    input  logic                 valid,
    input  logic [`DATA_W-1:0]   pc,
    input  id_pkg::instr_u       inst,
    input  logic [`BR_SEL_W-1:0] br_sel,
    output logic                 br_taken,
    output logic [`DATA_W-1:0]   br_target,
    rf_read_if.monitor           rf
);

    logic [`DATA_W-1:0]   pc_plus4;
    logic [`DATA_W-1:0]   br_offset;
    logic                 rs_zero;
    logic                 rs_neg;
    logic [`BR_SEL_W-1:0] cond;

    assign pc_plus4  = pc + `DATA_W'(4);
    assign br_offset = {{(`DATA_W-18){inst.ij.body.f.imm16[15]}}, inst.ij.body.f.imm16, 2'b00};
    assign rs_zero   = (rf.rs_data == '0);
    assign rs_neg    = rf.rs_data[`DATA_W-1];

    assign cond[`BR_EQ]  = (rf.rs_data == rf.rt_data);
    assign cond[`BR_NE]  = (rf.rs_data != rf.rt_data);
    assign cond[`BR_GEZ] = !rs_neg;
    assign cond[`BR_GTZ] = !rs_neg && !rs_zero;
    assign cond[`BR_LEZ] = rs_neg || rs_zero;
    assign cond[`BR_LTZ] = rs_neg;
    // jumps always go
    assign cond[`BR_J]   = 1'b1;
    assign cond[`BR_JR]  = 1'b1;

    assign br_taken = |(br_sel & cond);

    always_comb begin
        if (br_sel[`BR_JR]) begin
            br_target = rf.rs_data;
        end else if (br_sel[`BR_J]) begin
            br_target = {pc_plus4[`DATA_W-1 -: 4], inst.ij.body.index, 2'b00};
        end else if (|br_sel) begin
            br_target = pc_plus4 + br_offset;
        end else begin
            br_target = '0;
        end
    end

    // selects come from the decoder, which gates on valid
    taken_needs_valid: assert final (!br_taken || valid)
        else $error("branch taken with no valid instruction");

endmodule

// ==== hw/id_stage.sv ====
`timescale 1ns/1ps
`include "id_consts.svh"

module id_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall_if,
    input  logic                  stall_id,
    input  logic                  if_valid,
    input  logic [`DATA_W-1:0]    if_pc,
    input  logic [`DATA_W-1:0]    if_inst,
    input  logic                  ex_we,
    input  logic [`REG_AW-1:0]    ex_waddr,
    input  logic [`DATA_W-1:0]    ex_wdata,
    input  logic                  ex_is_load,
    input  logic                  mem_we,
    input  logic [`REG_AW-1:0]    mem_waddr,
    input  logic [`DATA_W-1:0]    mem_wdata,
    input  logic                  wb_we,
    input  logic [`REG_AW-1:0]    wb_waddr,
    input  logic [`DATA_W-1:0]    wb_wdata,
    output logic                  id_valid,
    output logic [`DATA_W-1:0]    id_pc,
    output logic [`ALU_OP_W-1:0]  alu_op,
    output logic [`SRC1_W-1:0]    alu_src1,
    output logic [`SRC2_W-1:0]    alu_src2,
    output logic                  mem_en,
    output logic [`MEM_WEN_W-1:0] mem_wen,
    output logic                  rf_we,
    output logic [`REG_AW-1:0]    rf_waddr,
    output logic [`DATA_W-1:0]    rs_data,
    output logic [`DATA_W-1:0]    rt_data,
    output logic                  br_taken,
    output logic [`DATA_W-1:0]    br_target,
    output logic                  stall_req
);
    import id_pkg::*;

    instr_u               id_inst;
    logic [`BR_SEL_W-1:0] br_sel;

    rf_read_if rf ();

    id_pipe_reg u_pipe_reg (
        .clk      (clk),
        .rst      (rst),
        .stall_if (stall_if),
        .stall_id (stall_id),
        .in_valid (if_valid),
        .in_pc    (if_pc),
        .in_inst  (if_inst),
        .valid    (id_valid),
        .pc       (id_pc),
        .inst     (id_inst)
    );

    inst_decoder u_decoder (
        .valid    (id_valid),
        .inst     (id_inst),
        .alu_op   (alu_op),
        .alu_src1 (alu_src1),
        .alu_src2 (alu_src2),
        .mem_en   (mem_en),
        .mem_wen  (mem_wen),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .br_sel   (br_sel),
        .rf       (rf.reader)
    );

    operand_fetch u_operand_fetch (
        .clk        (clk),
        .valid      (id_valid),
        .ex_we      (ex_we),
        .ex_waddr   (ex_waddr),
        .ex_wdata   (ex_wdata),
        .ex_is_load (ex_is_load),
        .mem_we     (mem_we),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .wb_we      (wb_we),
        .wb_waddr   (wb_waddr),
        .wb_wdata   (wb_wdata),
        .stall_req  (stall_req),
        .rf         (rf.source)
    );

    branch_unit u_branch_unit (
        .valid     (id_valid),
        .pc        (id_pc),
        .inst      (id_inst),
        .br_sel    (br_sel),
        .br_taken  (br_taken),
        .br_target (br_target),
        .rf        (rf.monitor)
    );

    assign rs_data = rf.rs_data;
    assign rt_data = rf.rt_data;

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // released shortly after an edge, like the other stimulus
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

// ==== test/tb_id_stage.sv ====
`timescale 1ns/1ps
`include "id_consts.svh"

module tb_id_stage;
    import id_pkg::*;

    localparam int N_RANDOM    = 400;
    localparam int TEST_CYCLES = 3 + 31 + N_RANDOM + 4;

    localparam logic [5:0] FUNCTS [18] = '{`FN_ADDU, `FN_SUBU, `FN_ADD, `FN_SUB, `FN_AND,
        `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU, `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV,
        `FN_SRLV, `FN_SRAV, `FN_JR, `FN_JALR};
    localparam logic [5:0] I_OPS [10] = '{`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
        `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI, `OP_LW, `OP_SW};
    localparam logic [5:0] B_OPS [7] = '{`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ,
        `OP_REGIMM, `OP_J, `OP_JAL};
    localparam logic [4:0] RT_CODES [4] = '{`RT_BLTZ, `RT_BGEZ, `RT_BLTZAL, `RT_BGEZAL};

    logic clk;
    logic rst;
    logic stall_if;
    logic stall_id;
    logic if_valid;
    logic [31:0] if_pc;
    logic [31:0] if_inst;
    logic ex_we;
    logic ex_is_load;
    logic mem_we;
    logic wb_we;
    logic [4:0] ex_waddr;
    logic [4:0] mem_waddr;
    logic [4:0] wb_waddr;
    logic [31:0] ex_wdata;
    logic [31:0] mem_wdata;
    logic [31:0] wb_wdata;
    logic id_valid;
    logic [31:0] id_pc;
    logic [`ALU_OP_W-1:0] alu_op;
    logic [`SRC1_W-1:0] alu_src1;
    logic [`SRC2_W-1:0] alu_src2;
    logic mem_en;
    logic [`MEM_WEN_W-1:0] mem_wen;
    logic rf_we;
    logic [4:0] rf_waddr;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic br_taken;
    logic [31:0] br_target;
    logic stall_req;

    // reference state: pipeline register and register file shadow
    logic m_valid;
    logic [31:0] m_pc;
    instr_u m_inst;
    logic [31:0] m_regs [32];

    logic [`ALU_OP_W-1:0] exp_op;
    logic [`SRC1_W-1:0] exp_src1;
    logic [`SRC2_W-1:0] exp_src2;
    logic exp_mem;
    logic exp_sw;
    logic exp_we;
    logic [4:0] exp_waddr;
    logic [31:0] exp_rs;
    logic [31:0] exp_rt;
    logic exp_br;
    logic exp_cond;
    logic exp_taken;
    logic [31:0] exp_target;
    logic exp_stall;

    logic [31:0] rng_state = 32'hc141_bade;
    int err_count = 0;

    tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(3)) u_clk_gen (.clk(clk), .rst(rst));

    id_stage uut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic next_rand(output logic [31:0] v);
        rng_state = xorshift32(rng_state);
        v = rng_state;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        err_count++;
        $display("FAILED %s: got %h expected %h", name, got, want);
        $display("ERRORS FOUND");
        $fatal(1, "mismatch on %s", name);
    endtask

    // mostly kept instructions, now and then an arbitrary word
    task automatic make_inst(output logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [5:0] op;
        next_rand(a);
        next_rand(b);
        rs = {1'b0, a[3:0]};
        rt = {1'b0, a[7:4]};
        case (a[9:8])
            2'd0: w = {`OP_SPECIAL, rs, rt, b[4:0],
                       (b[31:28] == 4'd0) ? b[9:5] : 5'd0, FUNCTS[b[14:10] % 18]};
            2'd1: w = {I_OPS[b[3:0] % 10], rs, rt, b[31:16]};
            2'd2: begin
                op = B_OPS[b[2:0] % 7];
                w = {op, rs, (op == `OP_REGIMM) ? RT_CODES[b[6:5]] : rt, b[31:16]};
            end
            default: w = a[10] ? b : {`OP_REGIMM, rs, RT_CODES[b[6:5]], b[31:16]};
        endcase
    endtask

    function automatic logic [31:0] forwarded_value(input logic [4:0] a);
        if (a == 5'd0) return '0;
        if (ex_we && ex_waddr == a) return ex_wdata;
        if (mem_we && mem_waddr == a) return mem_wdata;
        if (wb_we && wb_waddr == a) return wb_wdata;
        return m_regs[a];
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
            m_pc    <= '0;
            m_inst  <= '0;
        end else if (!stall_if) begin
            m_valid <= if_valid;
            m_pc    <= if_pc;
            m_inst  <= if_inst;
        end else if (!stall_id) begin
            m_valid <= 1'b0;
            m_inst  <= '0;
        end
        if (wb_we) begin
            m_regs[wb_waddr] <= wb_wdata;
        end
    end

    always_comb begin
        logic [5:0] op;
        logic [5:0] fn;
        logic [31:0] pc4;
        logic [31:0] simm;
        logic [`ALU_OP_W-1:0] r_op;
        logic [`ALU_OP_W-1:0] i_op;
        logic link;
        logic [4:0] link_dst;
        op = m_inst.r.opcode;
        fn = m_inst.r.funct;
        pc4 = m_pc + 32'd4;
        simm = {{16{m_inst.ij.body.f.imm16[15]}}, m_inst.ij.body.f.imm16};
        r_op = '0;
        i_op = '0;
        link = 1'b0;
        link_dst = 5'd`LINK_REG;
        exp_op = '0;
        exp_src1 = '0;
        exp_src2 = '0;
        exp_mem = 1'b0;
        exp_sw = 1'b0;
        exp_we = 1'b0;
        exp_waddr = '0;
        exp_br = 1'b0;
        exp_cond = 1'b0;
        exp_target = pc4 + (simm << 2);
        exp_rs = forwarded_value(m_inst.r.rs);
        exp_rt = forwarded_value(m_inst.r.rt);
        case (fn)
            `FN_ADD, `FN_ADDU: r_op[`ALU_ADD] = 1'b1;
            `FN_SUB, `FN_SUBU: r_op[`ALU_SUB] = 1'b1;
            `FN_AND: r_op[`ALU_AND] = 1'b1;
            `FN_OR: r_op[`ALU_OR] = 1'b1;
            `FN_XOR: r_op[`ALU_XOR] = 1'b1;
            `FN_NOR: r_op[`ALU_NOR] = 1'b1;
            `FN_SLT: r_op[`ALU_SLT] = 1'b1;
            `FN_SLTU: r_op[`ALU_SLTU] = 1'b1;
            `FN_SLL, `FN_SLLV: r_op[`ALU_SLL] = 1'b1;
            `FN_SRL, `FN_SRLV: r_op[`ALU_SRL] = 1'b1;
            `FN_SRA, `FN_SRAV: r_op[`ALU_SRA] = 1'b1;
            default: ;
        endcase
        case (op)
            `OP_ADDI, `OP_ADDIU: i_op[`ALU_ADD] = 1'b1;
            `OP_SLTI: i_op[`ALU_SLT] = 1'b1;
            `OP_SLTIU: i_op[`ALU_SLTU] = 1'b1;
            `OP_ANDI: i_op[`ALU_AND] = 1'b1;
            `OP_ORI: i_op[`ALU_OR] = 1'b1;
            `OP_XORI: i_op[`ALU_XOR] = 1'b1;
            `OP_LUI: i_op[`ALU_LUI] = 1'b1;
            default: ;
        endcase
        if (m_valid) begin
            case (op)
                `OP_SPECIAL: begin
                    if (fn == `FN_SLL || fn == `FN_SRL || fn == `FN_SRA) begin
                        exp_op = r_op;
                        exp_src1[`SRC1_SA] = 1'b1;
                        exp_src2[`SRC2_RT] = 1'b1;
                        exp_we = 1'b1;
                        exp_waddr = m_inst.r.rd;
                    end else if (m_inst.r.shamt == 5'd0) begin
                        if (|r_op) begin
                            exp_op = r_op;
                            exp_src1[`SRC1_RS] = 1'b1;
                            exp_src2[`SRC2_RT] = 1'b1;
                            exp_we = 1'b1;
                            exp_waddr = m_inst.r.rd;
                        end else if (fn == `FN_JR || fn == `FN_JALR) begin
                            exp_br = 1'b1;
                            exp_cond = 1'b1;
                            exp_target = exp_rs;
                            link = (fn == `FN_JALR);
                            link_dst = m_inst.r.rd;
                        end
                    end
                end
                `OP_LW, `OP_SW: begin
                    exp_op[`ALU_ADD] = 1'b1;
                    exp_src1[`SRC1_RS] = 1'b1;
                    exp_src2[`SRC2_SIMM] = 1'b1;
                    exp_mem = 1'b1;
                    exp_sw = (op == `OP_SW);
                    exp_we = (op == `OP_LW);
                    exp_waddr = exp_we ? m_inst.r.rt : 5'd0;
                end
                `OP_BEQ: {exp_br, exp_cond} = {1'b1, exp_rs == exp_rt};
                `OP_BNE: {exp_br, exp_cond} = {1'b1, exp_rs != exp_rt};
                `OP_BLEZ: {exp_br, exp_cond} = {1'b1, $signed(exp_rs) <= 0};
                `OP_BGTZ: {exp_br, exp_cond} = {1'b1, $signed(exp_rs) > 0};
                `OP_REGIMM: begin
                    case (m_inst.r.rt)
                        `RT_BGEZ, `RT_BGEZAL: {exp_br, exp_cond} = {1'b1, $signed(exp_rs) >= 0};
                        `RT_BLTZ, `RT_BLTZAL: {exp_br, exp_cond} = {1'b1, $signed(exp_rs) < 0};
                        default: ;
                    endcase
                    link = (m_inst.r.rt == `RT_BGEZAL || m_inst.r.rt == `RT_BLTZAL);
                end
                `OP_J, `OP_JAL: begin
                    exp_br = 1'b1;
                    exp_cond = 1'b1;
                    exp_target = {pc4[31:28], m_inst.ij.body.index, 2'b00};
                    link = (op == `OP_JAL);
                end
                default: begin
                    if (|i_op) begin
                        exp_op = i_op;
                        exp_src1[`SRC1_RS] = 1'b1;
                        if (op == `OP_ANDI || op == `OP_ORI || op == `OP_XORI) begin
                            exp_src2[`SRC2_ZIMM] = 1'b1;
                        end else begin
                            exp_src2[`SRC2_SIMM] = 1'b1;
                        end
                        exp_we = 1'b1;
                        exp_waddr = m_inst.r.rt;
                    end
                end
            endcase
            if (link) begin
                exp_op[`ALU_ADD] = 1'b1;
                exp_src1[`SRC1_PC] = 1'b1;
                exp_src2[`SRC2_C8] = 1'b1;
                exp_we = 1'b1;
                exp_waddr = link_dst;
            end
        end
        exp_taken = exp_br && exp_cond;
        exp_stall = m_valid && ex_is_load && ex_we
                 && (ex_waddr == m_inst.r.rs || ex_waddr == m_inst.r.rt);
    end

    chk_valid: assert property (@(posedge clk) disable iff (rst) id_valid == m_valid)
        else report_mismatch("id_valid", $sampled(id_valid), $sampled(m_valid));
    chk_pc: assert property (@(posedge clk) disable iff (rst) m_valid |-> id_pc == m_pc)
        else report_mismatch("id_pc", $sampled(id_pc), $sampled(m_pc));
    chk_alu_op: assert property (@(posedge clk) disable iff (rst) alu_op == exp_op)
        else report_mismatch("alu_op", $sampled(alu_op), $sampled(exp_op));
    chk_src1: assert property (@(posedge clk) disable iff (rst) alu_src1 == exp_src1)
        else report_mismatch("alu_src1", $sampled(alu_src1), $sampled(exp_src1));
    chk_src2: assert property (@(posedge clk) disable iff (rst) alu_src2 == exp_src2)
        else report_mismatch("alu_src2", $sampled(alu_src2), $sampled(exp_src2));
    chk_mem_en: assert property (@(posedge clk) disable iff (rst) mem_en == exp_mem)
        else report_mismatch("mem_en", $sampled(mem_en), $sampled(exp_mem));
    chk_mem_wen: assert property (@(posedge clk) disable iff (rst) mem_wen == {4{exp_sw}})
        else report_mismatch("mem_wen", $sampled(mem_wen), {4{$sampled(exp_sw)}});
    chk_rf_we: assert property (@(posedge clk) disable iff (rst) rf_we == exp_we)
        else report_mismatch("rf_we", $sampled(rf_we), $sampled(exp_we));
    chk_waddr: assert property (@(posedge clk) disable iff (rst) exp_we |-> rf_waddr == exp_waddr)
        else report_mismatch("rf_waddr", $sampled(rf_waddr), $sampled(exp_waddr));
    chk_rs: assert property (@(posedge clk) disable iff (rst) rs_data == exp_rs)
        else report_mismatch("rs_data", $sampled(rs_data), $sampled(exp_rs));
    chk_rt: assert property (@(posedge clk) disable iff (rst) rt_data == exp_rt)
        else report_mismatch("rt_data", $sampled(rt_data), $sampled(exp_rt));
    chk_taken: assert property (@(posedge clk) disable iff (rst) br_taken == exp_taken)
        else report_mismatch("br_taken", $sampled(br_taken), $sampled(exp_taken));
    chk_target: assert property (@(posedge clk) disable iff (rst) exp_br |-> br_target == exp_target)
        else report_mismatch("br_target", $sampled(br_target), $sampled(exp_target));
    chk_stall: assert property (@(posedge clk) disable iff (rst) stall_req == exp_stall)
        else report_mismatch("stall_req", $sampled(stall_req), $sampled(exp_stall));

    initial begin
        #(TEST_CYCLES * 40 + 4000);
        $display("watchdog expired before the test sequence finished");
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        {stall_if, stall_id, if_valid, if_pc, if_inst} = '0;
        {ex_we, ex_is_load, ex_waddr, ex_wdata} = '0;
        {mem_we, mem_waddr, mem_wdata, wb_we, wb_waddr, wb_wdata} = '0;
        wait (!rst);
        // fill every register through wb while id holds bubbles
        for (int i = 1; i < 32; i++) begin
            wb_we = 1'b1;
            wb_waddr = 5'(i);
            next_rand(wb_wdata);
            next_cycle();
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            next_rand(r);
            next_rand(d);
            stall_if = (r[3:0] == 4'd0);
            stall_id = stall_if && r[4];
            if_valid = (r[7:5] != 3'd0);
            make_inst(if_inst);
            if_pc = {d[31:2], 2'b00};
            ex_we = r[8];
            ex_is_load = r[9];
            mem_we = r[10];
            wb_we = r[11];
            ex_waddr = {1'b0, r[15:12]};
            mem_waddr = {1'b0, r[19:16]};
            wb_waddr = {1'b0, r[23:20]};
            next_rand(ex_wdata);
            next_rand(mem_wdata);
            next_rand(wb_wdata);
            if (r[26:24] == 3'd0) begin
                // all three stages aim at the rs of the instruction in id
                // ex only sometimes writes, so mem against wb also gets decided
                {ex_we, mem_we, wb_we} = {r[27], 2'b11};
                ex_waddr = m_inst.r.rs;
                mem_waddr = m_inst.r.rs;
                wb_waddr = m_inst.r.rs;
            end
            next_cycle();
        end
        next_cycle();
        next_cycle();
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hw
hw/id_pkg.sv
hw/rf_read_if.sv
hw/id_pipe_reg.sv
hw/inst_decoder.sv
hw/operand_fetch.sv
hw/branch_unit.sv
hw/id_stage.sv
test/tb_clk_gen.sv
test/tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/id_pkg.sv
      - hw/rf_read_if.sv
      - hw/id_pipe_reg.sv
      - hw/inst_decoder.sv
      - hw/operand_fetch.sv
      - hw/branch_unit.sv
      - hw/id_stage.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_clk_gen.sv
      - test/tb_id_stage.sv
